// File: verilog/dii_pkg.sv
package dii_pkg;

   // One flit on a debug link.
   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   // Third flit of a packet is the header, later flits are payload.
   typedef union packed {
      struct packed {
         logic [1:0] pkt_type;
         logic [3:0] type_sub;
         logic [9:0] reserved;
      } hdr;
      logic [15:0] raw;
   } dii_hdr_word;

   ////////////////////////////////////////
   // Module ids

   localparam logic [15:0] ID_HOST = 16'd0;
   localparam logic [15:0] ID_SCM  = 16'd1;
   localparam logic [15:0] ID_UART = 16'd2;

   ////////////////////////////////////////
   // Packet types and register subtypes

   localparam logic [1:0] TYPE_REG   = 2'b00;
   localparam logic [1:0] TYPE_EVENT = 2'b10;

   localparam logic [3:0] SUB_REQ_READ       = 4'b0000;
   localparam logic [3:0] SUB_REQ_WRITE      = 4'b0100;
   localparam logic [3:0] SUB_RESP_READ      = 4'b0000;
   localparam logic [3:0] SUB_RESP_READ_ERR  = 4'b1100;
   localparam logic [3:0] SUB_RESP_WRITE     = 4'b1110;
   localparam logic [3:0] SUB_RESP_WRITE_ERR = 4'b1111;

endpackage

// File: verilog/osd_reg_pkg.sv
package osd_reg_pkg;

   ////////////////////////////////////////
   // System control module

   localparam logic [15:0] REG_SYSTEM_ID = 16'h0200;
   localparam logic [15:0] REG_NUM_MOD   = 16'h0201;
   localparam logic [15:0] REG_SYSCTRL   = 16'h0203;

   localparam logic [15:0] SYSTEM_ID_VALUE = 16'hdead;
   localparam logic [15:0] NUM_MOD_VALUE   = 16'd2;

   localparam int SYSCTRL_SYS_RST_BIT = 0;
   localparam int SYSCTRL_CPU_RST_BIT = 1;

   typedef struct packed {
      logic [15:0] src;
      logic        write;
      logic [15:0] addr;
      logic [15:0] wdata;
   } scm_req;

   typedef struct packed {
      logic [15:0] dest;
      logic [3:0]  sub;
      logic        has_data;        // Read success only.
      logic [15:0] rdata;
   } scm_resp;

   ////////////////////////////////////////
   // UART emulation

   localparam logic [2:0] UART_OFS_DATA = 3'd0;
   localparam logic [2:0] UART_OFS_LSR  = 3'd5;

   localparam int LSR_DR_BIT   = 0;
   localparam int LSR_THRE_BIT = 5;

   localparam logic [1:0] AXIL_OKAY   = 2'b00;
   localparam logic [1:0] AXIL_SLVERR = 2'b10;

endpackage

// File: verilog/dii_switch.sv
module dii_switch
   import dii_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n,
   input  dii_flit       host_in,
   output logic          host_in_ready,
   output dii_flit       host_out,
   input  logic          host_out_ready,
   output dii_flit [1:0] mod_out,
   input  logic    [1:0] mod_out_ready,
   input  dii_flit [1:0] mod_in,
   output logic    [1:0] mod_in_ready
);

   ////////////////////////////////////////
   // Host to modules

   logic in_busy;
   logic in_drop;
   logic in_port;
   logic cur_drop;
   logic cur_port;
   logic in_fire;

   always_comb begin
      if (in_busy) begin
         cur_drop = in_drop;
         cur_port = in_port;
      end else begin
         cur_drop = (host_in.data != ID_SCM) && (host_in.data != ID_UART);
         cur_port = (host_in.data == ID_UART);
      end
   end

   always_comb begin
      mod_out[0] = host_in;
      mod_out[1] = host_in;
      mod_out[0].valid = host_in.valid & ~cur_drop & ~cur_port;
      mod_out[1].valid = host_in.valid & ~cur_drop & cur_port;
   end

   assign host_in_ready = cur_drop | mod_out_ready[cur_port]; // Unknown ids sink.
   assign in_fire = host_in.valid & host_in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_busy <= 1'b0;
         in_drop <= 1'b0;
         in_port <= 1'b0;
      end else if (in_fire) begin
         in_busy <= ~host_in.last;
         in_drop <= cur_drop;
         in_port <= cur_port;
      end
   end

   ////////////////////////////////////////
   // Modules to host

   logic out_busy;
   logic out_owner;
   logic rr_ptr;
   logic pick;
   logic cur_owner;
   logic out_fire;

   assign pick = mod_in[rr_ptr].valid ? rr_ptr : ~rr_ptr;
   assign cur_owner = out_busy ? out_owner : pick;
   assign host_out = mod_in[cur_owner];
   assign mod_in_ready[0] = host_out_ready & ~cur_owner;
   assign mod_in_ready[1] = host_out_ready & cur_owner;
   assign out_fire = host_out.valid & host_out_ready;

   // Owner locks as soon as a flit is offered, so host_out stays stable.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_busy  <= 1'b0;
         out_owner <= 1'b0;
         rr_ptr    <= 1'b0;
      end else if (host_out.valid) begin
         if (out_fire && host_out.last) begin
            out_busy <= 1'b0;
            rr_ptr   <= ~cur_owner;                          // Other side first.
         end else begin
            out_busy  <= 1'b1;
            out_owner <= cur_owner;
         end
      end
   end

endmodule

// File: verilog/dii_pkt_decode.sv
module dii_pkt_decode
   import dii_pkg::*;
   import osd_reg_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  dii_flit pkt_in,
   output logic    pkt_in_ready,
   output scm_req  req,
   output logic    req_valid,
   input  logic    req_ready
);

   dii_hdr_word word;
   logic [2:0]  cnt;
   logic        keep;
   logic        fire;

   assign word.raw = pkt_in.data;
   assign pkt_in_ready = ~req_valid;                         // Hold off while full.
   assign fire = pkt_in.valid & pkt_in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt       <= 3'd0;
         keep      <= 1'b0;
         req_valid <= 1'b0;
      end else begin
         if (req_valid && req_ready) begin
            req_valid <= 1'b0;
         end
         if (fire) begin
            if (pkt_in.last) begin
               cnt       <= 3'd0;
               req_valid <= keep && (cnt == (req.write ? 3'd4 : 3'd3));
            end else if (cnt != 3'd7) begin
               cnt <= cnt + 3'd1;
            end
            if (cnt == 3'd2) begin
               keep <= (word.hdr.pkt_type == TYPE_REG) &&
                       (word.hdr.type_sub == SUB_REQ_READ ||
                        word.hdr.type_sub == SUB_REQ_WRITE);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         case (cnt)
            3'd1: req.src <= word.raw;
            3'd2: req.write <= (word.hdr.type_sub == SUB_REQ_WRITE);
            3'd3: req.addr <= word.raw;
            3'd4: req.wdata <= word.raw;
            default: ;                                        // Destination word.
         endcase
      end
   end

endmodule

// File: verilog/scm_reg_execute.sv
module scm_reg_execute
   import dii_pkg::*;
   import osd_reg_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  scm_req  req,
   input  logic    req_valid,
   output logic    req_ready,
   output scm_resp resp,
   output logic    resp_valid,
   input  logic    resp_ready,
   output logic    sys_rst,
   output logic    cpu_rst
);

   logic [15:0] sysctrl;
   logic        fire;

   assign req_ready = ~resp_valid;
   assign fire = req_valid & req_ready;

   assign sys_rst = sysctrl[SYSCTRL_SYS_RST_BIT];
   assign cpu_rst = sysctrl[SYSCTRL_CPU_RST_BIT];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sysctrl    <= 16'h0000;
         resp_valid <= 1'b0;
      end else begin
         if (resp_valid && resp_ready) begin
            resp_valid <= 1'b0;
         end
         if (fire) begin
            resp_valid <= 1'b1;
            if (req.write && req.addr == REG_SYSCTRL) begin
               sysctrl <= req.wdata;                          // Only writable register.
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         resp.dest  <= req.src;
         resp.rdata <= 16'h0000;
         if (req.write) begin
            resp.has_data <= 1'b0;
            resp.sub <= (req.addr == REG_SYSCTRL) ? SUB_RESP_WRITE : SUB_RESP_WRITE_ERR;
         end else begin
            resp.has_data <= 1'b1;
            resp.sub      <= SUB_RESP_READ;
            case (req.addr)
               REG_SYSTEM_ID: resp.rdata <= SYSTEM_ID_VALUE;
               REG_NUM_MOD: resp.rdata <= NUM_MOD_VALUE;
               REG_SYSCTRL: resp.rdata <= sysctrl;
               default: begin
                  resp.has_data <= 1'b0;                      // Error reply has no payload.
                  resp.sub      <= SUB_RESP_READ_ERR;
               end
            endcase
         end
      end
   end

endmodule

// File: verilog/dii_pkt_result.sv
module dii_pkt_result
   import dii_pkg::*;
   import osd_reg_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  scm_resp resp,
   input  logic    resp_valid,
   output logic    resp_ready,
   output dii_flit pkt_out,
   input  logic    pkt_out_ready
);

   scm_resp     rsp;
   logic        busy;
   logic [1:0]  cnt;
   logic        fire;
   dii_hdr_word hdr_word;

   assign resp_ready = ~busy;
   assign fire = pkt_out.valid & pkt_out_ready;

   always_comb begin
      hdr_word.raw          = 16'h0000;
      hdr_word.hdr.pkt_type = TYPE_REG;
      hdr_word.hdr.type_sub = rsp.sub;
   end

   always_comb begin
      pkt_out.valid = busy;
      pkt_out.last  = (cnt == 2'd3) || (cnt == 2'd2 && !rsp.has_data);
      case (cnt)
         2'd0: pkt_out.data = rsp.dest;
         2'd1: pkt_out.data = ID_SCM;
         2'd2: pkt_out.data = hdr_word.raw;
         default: pkt_out.data = rsp.rdata;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy <= 1'b0;
         cnt  <= 2'd0;
      end else if (!busy) begin
         if (resp_valid) begin
            busy <= 1'b1;
            cnt  <= 2'd0;
         end
      end else if (fire) begin
         if (pkt_out.last) begin
            busy <= 1'b0;
         end else begin
            cnt <= cnt + 2'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (resp_valid && resp_ready) begin
         rsp <= resp;
      end
   end

endmodule

// File: verilog/osd_dem_uart.sv
module osd_dem_uart
   import dii_pkg::*;
   import osd_reg_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [12:0] s_axil_awaddr,
   input  logic        s_axil_awvalid,
   output logic        s_axil_awready,
   input  logic [31:0] s_axil_wdata,
   input  logic        s_axil_wvalid,
   output logic        s_axil_wready,
   output logic [1:0]  s_axil_bresp,
   output logic        s_axil_bvalid,
   input  logic        s_axil_bready,
   input  logic [12:0] s_axil_araddr,
   input  logic        s_axil_arvalid,
   output logic        s_axil_arready,
   output logic [31:0] s_axil_rdata,
   output logic [1:0]  s_axil_rresp,
   output logic        s_axil_rvalid,
   input  logic        s_axil_rready,
   input  dii_flit     debug_in,
   output logic        debug_in_ready,
   output dii_flit     debug_out,
   input  logic        debug_out_ready
);

   logic [2:0]  wr_ofs;
   logic [2:0]  rd_ofs;
   logic        wr_fire;
   logic        rd_fire;
   logic        tx_busy;
   logic [1:0]  tx_cnt;
   logic [7:0]  tx_char;
   logic        tx_fire;
   logic        rx_full;
   logic [7:0]  rx_char;
   logic [2:0]  rx_cnt;
   logic        rx_keep;
   logic        rx_fire;
   logic [7:0]  lsr;
   logic [7:0]  rd_byte;
   dii_hdr_word rx_word;
   dii_hdr_word tx_hdr;

   ////////////////////////////////////////
   // AXI4-Lite handshakes

   assign wr_ofs = s_axil_awaddr[4:2];
   assign rd_ofs = s_axil_araddr[4:2];

   assign s_axil_awready = ~tx_busy & ~s_axil_bvalid;       // Busy while sending.
   assign s_axil_wready  = s_axil_awready;
   assign s_axil_arready = ~s_axil_rvalid;
   assign s_axil_rdata   = {24'h000000, rd_byte};

   assign wr_fire = s_axil_awvalid & s_axil_wvalid & s_axil_awready & s_axil_wready;
   assign rd_fire = s_axil_arvalid & s_axil_arready;

   always_comb begin
      lsr               = 8'h00;
      lsr[LSR_DR_BIT]   = rx_full;
      lsr[LSR_THRE_BIT] = ~tx_busy;
   end

   ////////////////////////////////////////
   // Debug packets

   assign rx_word.raw    = debug_in.data;
   assign debug_in_ready = ~rx_full;                         // One-entry buffer.
   assign rx_fire        = debug_in.valid & debug_in_ready;
   assign tx_fire        = debug_out.valid & debug_out_ready;

   always_comb begin
      tx_hdr.raw          = 16'h0000;
      tx_hdr.hdr.pkt_type = TYPE_EVENT;
      debug_out.valid     = tx_busy;
      debug_out.last      = (tx_cnt == 2'd3);
      case (tx_cnt)
         2'd0: debug_out.data = ID_HOST;
         2'd1: debug_out.data = ID_UART;
         2'd2: debug_out.data = tx_hdr.raw;
         default: debug_out.data = {8'h00, tx_char};
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s_axil_bvalid <= 1'b0;
         s_axil_rvalid <= 1'b0;
         tx_busy       <= 1'b0;
         tx_cnt        <= 2'd0;
         rx_full       <= 1'b0;
         rx_cnt        <= 3'd0;
         rx_keep       <= 1'b0;
      end else begin
         if (s_axil_bvalid && s_axil_bready) begin
            s_axil_bvalid <= 1'b0;
         end
         if (wr_fire) begin
            s_axil_bvalid <= 1'b1;
            if (wr_ofs == UART_OFS_DATA) begin
               tx_busy <= 1'b1;
               tx_cnt  <= 2'd0;
            end
         end
         if (tx_fire) begin
            if (debug_out.last) begin
               tx_busy <= 1'b0;
            end else begin
               tx_cnt <= tx_cnt + 2'd1;
            end
         end
         if (s_axil_rvalid && s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
         end
         if (rd_fire) begin
            s_axil_rvalid <= 1'b1;
            if (rd_ofs == UART_OFS_DATA) begin
               rx_full <= 1'b0;                               // Character taken.
            end
         end
         if (rx_fire) begin
            if (debug_in.last) begin
               rx_cnt <= 3'd0;
               if (rx_keep && rx_cnt == 3'd3) begin
                  rx_full <= 1'b1;
               end
            end else if (rx_cnt != 3'd7) begin
               rx_cnt <= rx_cnt + 3'd1;
            end
            if (rx_cnt == 3'd2) begin
               rx_keep <= (rx_word.hdr.pkt_type == TYPE_EVENT); // Register packets dropped.
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         s_axil_bresp <= (wr_ofs == UART_OFS_DATA || wr_ofs == UART_OFS_LSR) ?
                         AXIL_OKAY : AXIL_SLVERR;
         if (wr_ofs == UART_OFS_DATA) begin
            tx_char <= s_axil_wdata[7:0];
         end
      end
      if (rd_fire) begin
         s_axil_rresp <= (rd_ofs == UART_OFS_DATA || rd_ofs == UART_OFS_LSR) ?
                         AXIL_OKAY : AXIL_SLVERR;
         case (rd_ofs)
            UART_OFS_DATA: rd_byte <= rx_char;
            UART_OFS_LSR: rd_byte <= lsr;
            default: rd_byte <= 8'h00;
         endcase
      end
      if (rx_fire && rx_cnt == 3'd3) begin
         rx_char <= rx_word.raw[7:0];
      end
   end

endmodule

// File: verilog/debug_system.sv
module debug_system
   import dii_pkg::*;
   import osd_reg_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  dii_flit     host_in,
   output logic        host_in_ready,
   output dii_flit     host_out,
   input  logic        host_out_ready,
   input  logic [12:0] s_axil_awaddr,
   input  logic        s_axil_awvalid,
   output logic        s_axil_awready,
   input  logic [31:0] s_axil_wdata,
   input  logic        s_axil_wvalid,
   output logic        s_axil_wready,
   output logic [1:0]  s_axil_bresp,
   output logic        s_axil_bvalid,
   input  logic        s_axil_bready,
   input  logic [12:0] s_axil_araddr,
   input  logic        s_axil_arvalid,
   output logic        s_axil_arready,
   output logic [31:0] s_axil_rdata,
   output logic [1:0]  s_axil_rresp,
   output logic        s_axil_rvalid,
   input  logic        s_axil_rready,
   output logic        sys_rst,
   output logic        cpu_rst
);

   // Port 0 is the system control module, port 1 the UART.
   dii_flit [1:0] sw_to_mod;
   logic    [1:0] sw_to_mod_ready;
   dii_flit [1:0] mod_to_sw;
   logic    [1:0] mod_to_sw_ready;

   scm_req  req;
   logic    req_valid;
   logic    req_ready;
   scm_resp resp;
   logic    resp_valid;
   logic    resp_ready;

   dii_switch u_switch (
      .clk            (clk),
      .rst_n          (rst_n),
      .host_in        (host_in),
      .host_in_ready  (host_in_ready),
      .host_out       (host_out),
      .host_out_ready (host_out_ready),
      .mod_out        (sw_to_mod),
      .mod_out_ready  (sw_to_mod_ready),
      .mod_in         (mod_to_sw),
      .mod_in_ready   (mod_to_sw_ready)
   );

   dii_pkt_decode u_decode (
      .clk          (clk),
      .rst_n        (rst_n),
      .pkt_in       (sw_to_mod[0]),
      .pkt_in_ready (sw_to_mod_ready[0]),
      .req          (req),
      .req_valid    (req_valid),
      .req_ready    (req_ready)
   );

   scm_reg_execute u_execute (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .sys_rst    (sys_rst),
      .cpu_rst    (cpu_rst)
   );

   dii_pkt_result u_result (
      .clk           (clk),
      .rst_n         (rst_n),
      .resp          (resp),
      .resp_valid    (resp_valid),
      .resp_ready    (resp_ready),
      .pkt_out       (mod_to_sw[0]),
      .pkt_out_ready (mod_to_sw_ready[0])
   );

   osd_dem_uart u_uart (
      .clk             (clk),
      .rst_n           (rst_n),
      .s_axil_awaddr   (s_axil_awaddr),
      .s_axil_awvalid  (s_axil_awvalid),
      .s_axil_awready  (s_axil_awready),
      .s_axil_wdata    (s_axil_wdata),
      .s_axil_wvalid   (s_axil_wvalid),
      .s_axil_wready   (s_axil_wready),
      .s_axil_bresp    (s_axil_bresp),
      .s_axil_bvalid   (s_axil_bvalid),
      .s_axil_bready   (s_axil_bready),
      .s_axil_araddr   (s_axil_araddr),
      .s_axil_arvalid  (s_axil_arvalid),
      .s_axil_arready  (s_axil_arready),
      .s_axil_rdata    (s_axil_rdata),
      .s_axil_rresp    (s_axil_rresp),
      .s_axil_rvalid   (s_axil_rvalid),
      .s_axil_rready   (s_axil_rready),
      .debug_in        (sw_to_mod[1]),
      .debug_in_ready  (sw_to_mod_ready[1]),
      .debug_out       (mod_to_sw[1]),
      .debug_out_ready (mod_to_sw_ready[1])
   );

endmodule

// File: test/debug_system_sva.sv
module debug_system_sva
   import dii_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input dii_flit    host_out,
   input logic       host_out_ready,
   input logic       s_axil_bvalid,
   input logic       s_axil_bready,
   input logic [1:0] s_axil_bresp,
   input logic       sys_rst,
   input logic       cpu_rst
);

   host_out_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      host_out.valid && !host_out_ready |=>
         host_out.valid && $stable(host_out.data) && $stable(host_out.last)
   ) else $error("host_out flit changed while stalled");

   bvalid_held: assert property (
      @(posedge clk) disable iff (!rst_n)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp)
   ) else $error("bvalid dropped before bready");

   // Control bits are cleared by the async reset.
   resets_low: assert property (
      @(posedge clk) !rst_n |-> !sys_rst && !cpu_rst
   ) else $error("sys_rst or cpu_rst high during reset");

endmodule

bind debug_system debug_system_sva u_sva (
   .clk            (clk),
   .rst_n          (rst_n),
   .host_out       (host_out),
   .host_out_ready (host_out_ready),
   .s_axil_bvalid  (s_axil_bvalid),
   .s_axil_bready  (s_axil_bready),
   .s_axil_bresp   (s_axil_bresp),
   .sys_rst        (sys_rst),
   .cpu_rst        (cpu_rst)
);

// File: test/tb_debug_system.sv
module tb_debug_system
   import dii_pkg::*;
   import osd_reg_pkg::*;
();

   localparam int WAIT_LIMIT = 200;

   logic        clk;
   logic        rst_n;
   dii_flit     host_in;
   logic        host_in_ready;
   dii_flit     host_out;
   logic        host_out_ready;
   logic [12:0] s_axil_awaddr;
   logic        s_axil_awvalid;
   logic        s_axil_awready;
   logic [31:0] s_axil_wdata;
   logic        s_axil_wvalid;
   logic        s_axil_wready;
   logic [1:0]  s_axil_bresp;
   logic        s_axil_bvalid;
   logic        s_axil_bready;
   logic [12:0] s_axil_araddr;
   logic        s_axil_arvalid;
   logic        s_axil_arready;
   logic [31:0] s_axil_rdata;
   logic [1:0]  s_axil_rresp;
   logic        s_axil_rvalid;
   logic        s_axil_rready;
   logic        sys_rst;
   logic        cpu_rst;

   dii_flit     rx_q[$];                                     // Flits taken from host_out.
   logic [15:0] tx_words [0:4];
   logic [15:0] exp_words [0:4];
   int          exp_len;
   int          checks;
   int          errors;
   logic        timed_out;

   debug_system DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   ////////////////////////////////////////
   // Host side receiver

   initial begin
      void'($urandom(32'h9740_4441));
      host_out_ready = 1'b0;
      forever begin
         @(negedge clk);
         host_out_ready = ($urandom_range(3) != 0);          // Stall about one cycle in four.
      end
   end

   always @(posedge clk) begin
      if (rst_n && host_out.valid && host_out_ready) begin
         rx_q.push_back(host_out);
      end
   end

   ////////////////////////////////////////
   // Checking helpers

   task compare_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (!timed_out && got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task note_timeout(input string what);
      if (!timed_out) begin
         errors++;
         $display("timeout at %0t while waiting for %s", $time, what);
      end
      timed_out = 1'b1;
   endtask

   task send_packet(input int len);
      int n;
      for (int i = 0; i < len; i++) begin
         @(negedge clk);
         host_in.valid = 1'b1;
         host_in.last  = (i == len - 1);
         host_in.data  = tx_words[i];
         n = 0;
         @(posedge clk);
         while (!host_in_ready && !timed_out) begin
            n++;
            if (n == WAIT_LIMIT) begin
               note_timeout("host_in_ready");
            end
            @(posedge clk);
         end
      end
      @(negedge clk);
      host_in = '0;
   endtask

   task check_packet(input string what);
      dii_flit f;
      int      n;
      for (int i = 0; i < exp_len; i++) begin
         n = 0;
         while (rx_q.size() == 0 && !timed_out) begin
            n++;
            if (n == WAIT_LIMIT) begin
               note_timeout($sformatf("%s flit %0d", what, i));
            end
            @(negedge clk);
         end
         if (timed_out) begin
            return;
         end
         f = rx_q.pop_front();
         compare_value($sformatf("host_out.data %s word %0d", what, i), 32'(f.data),
                       32'(exp_words[i]));
         compare_value($sformatf("host_out.last %s word %0d", what, i), 32'(f.last),
                       32'(i == exp_len - 1));
      end
   endtask

   task axi_write(input logic [2:0] ofs, input logic [31:0] data, output logic [1:0] resp);
      int n;
      @(negedge clk);
      s_axil_awaddr  = {8'h00, ofs, 2'b00};
      s_axil_awvalid = 1'b1;
      s_axil_wdata   = data;
      s_axil_wvalid  = 1'b1;
      n = 0;
      @(posedge clk);
      while (!(s_axil_awready && s_axil_wready) && !timed_out) begin
         n++;
         if (n == WAIT_LIMIT) begin
            note_timeout("s_axil_awready and s_axil_wready");
         end
         @(posedge clk);
      end
      @(negedge clk);
      s_axil_awvalid = 1'b0;
      s_axil_wvalid  = 1'b0;
      @(negedge clk);
      s_axil_bready = 1'b1;                                  // One cycle late, bvalid must hold.
      n = 0;
      @(posedge clk);
      while (!s_axil_bvalid && !timed_out) begin
         n++;
         if (n == WAIT_LIMIT) begin
            note_timeout("s_axil_bvalid");
         end
         @(posedge clk);
      end
      resp = s_axil_bresp;
      @(negedge clk);
      s_axil_bready = 1'b0;
   endtask

   task axi_read(input logic [2:0] ofs, output logic [31:0] data, output logic [1:0] resp);
      int n;
      @(negedge clk);
      s_axil_araddr  = {8'h00, ofs, 2'b00};
      s_axil_arvalid = 1'b1;
      n = 0;
      @(posedge clk);
      while (!s_axil_arready && !timed_out) begin
         n++;
         if (n == WAIT_LIMIT) begin
            note_timeout("s_axil_arready");
         end
         @(posedge clk);
      end
      @(negedge clk);
      s_axil_arvalid = 1'b0;
      @(negedge clk);
      s_axil_rready = 1'b1;
      n = 0;
      @(posedge clk);
      while (!s_axil_rvalid && !timed_out) begin
         n++;
         if (n == WAIT_LIMIT) begin
            note_timeout("s_axil_rvalid");
         end
         @(posedge clk);
      end
      data = s_axil_rdata;
      resp = s_axil_rresp;
      @(negedge clk);
      s_axil_rready = 1'b0;
   endtask

   ////////////////////////////////////////
   // Commands from the data file

   task reg_read(input logic [15:0] addr, input logic [3:0] sub, input logic [15:0] data);
      tx_words = '{ID_SCM, ID_HOST, {TYPE_REG, SUB_REQ_READ, 10'h000}, addr, 16'h0000};
      send_packet(4);
      exp_words = '{ID_HOST, ID_SCM, {TYPE_REG, sub, 10'h000}, data, 16'h0000};
      exp_len = (sub == SUB_RESP_READ) ? 4 : 3;             // Error reply carries no data.
      check_packet("read response");
   endtask

   task reg_write(input logic [15:0] addr, input logic [15:0] data, input logic [3:0] sub);
      tx_words = '{ID_SCM, ID_HOST, {TYPE_REG, SUB_REQ_WRITE, 10'h000}, addr, data};
      send_packet(5);
      exp_words = '{ID_HOST, ID_SCM, {TYPE_REG, sub, 10'h000}, 16'h0000, 16'h0000};
      exp_len = 3;
      check_packet("write response");
      if (addr == REG_SYSCTRL && sub == SUB_RESP_WRITE) begin
         @(negedge clk);
         compare_value("sys_rst", 32'(sys_rst), 32'(data[SYSCTRL_SYS_RST_BIT]));
         compare_value("cpu_rst", 32'(cpu_rst), 32'(data[SYSCTRL_CPU_RST_BIT]));
      end
   endtask

   task cpu_send(input logic [7:0] ch);
      logic [1:0]  resp;
      logic [31:0] rdata;
      axi_write(UART_OFS_DATA, {24'h000000, ch}, resp);
      compare_value("s_axil_bresp", 32'(resp), 32'(AXIL_OKAY));
      axi_read(UART_OFS_LSR, rdata, resp);
      compare_value("s_axil_rdata lsr while sending", rdata, 32'h0);
      exp_words = '{ID_HOST, ID_UART, {TYPE_EVENT, 4'h0, 10'h000}, {8'h00, ch}, 16'h0000};
      exp_len = 4;
      check_packet("uart event");
   endtask

   task host_send(input logic [7:0] ch);
      logic [1:0]  resp;
      logic [31:0] rdata;
      logic [31:0] lsr_idle;
      lsr_idle = 32'h1 << LSR_THRE_BIT;
      tx_words = '{ID_UART, ID_HOST, {TYPE_EVENT, 4'h0, 10'h000}, {8'h00, ch}, 16'h0000};
      send_packet(4);
      axi_read(UART_OFS_LSR, rdata, resp);
      compare_value("s_axil_rresp", 32'(resp), 32'(AXIL_OKAY));
      compare_value("s_axil_rdata lsr full", rdata, lsr_idle | (32'h1 << LSR_DR_BIT));
      axi_read(UART_OFS_DATA, rdata, resp);
      compare_value("s_axil_rresp char", 32'(resp), 32'(AXIL_OKAY));
      compare_value("s_axil_rdata char", rdata, {24'h000000, ch});
      axi_read(UART_OFS_LSR, rdata, resp);
      compare_value("s_axil_rdata lsr empty", rdata, lsr_idle);
   endtask

   task bad_offset(input logic [2:0] ofs);
      logic [1:0]  resp;
      logic [31:0] rdata;
      axi_write(ofs, 32'h0, resp);
      compare_value("s_axil_bresp", 32'(resp), 32'(AXIL_SLVERR));
      axi_read(ofs, rdata, resp);
      compare_value("s_axil_rresp", 32'(resp), 32'(AXIL_SLVERR));
      compare_value("s_axil_rdata", rdata, 32'h0);
   endtask

   initial begin
      int          fd;
      int          code;
      logic [7:0]  cmd;
      logic [15:0] field1;
      logic [15:0] field2;
      logic [15:0] field3;
      string       line;
      checks         = 0;
      errors         = 0;
      timed_out      = 1'b0;
      rst_n         <= 1'b0;
      host_in        = '0;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n <= 1'b1;

      fd = $fopen("test/debug_testdata.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("could not open the test data file");
      end else begin
         while (!timed_out) begin
            code = $fscanf(fd, " %c", cmd);
            if (code != 1) begin
               break;
            end
            case (cmd)
               "#": code = $fgets(line, fd);
               "R": begin
                  code = $fscanf(fd, "%h %h %h", field1, field2, field3);
                  reg_read(field1, field2[3:0], field3);
               end
               "W": begin
                  code = $fscanf(fd, "%h %h %h", field1, field2, field3);
                  reg_write(field1, field2, field3[3:0]);
               end
               "U": begin
                  code = $fscanf(fd, "%h", field1);
                  cpu_send(field1[7:0]);
               end
               "H": begin
                  code = $fscanf(fd, "%h", field1);
                  host_send(field1[7:0]);
               end
               "X": begin
                  code = $fscanf(fd, "%h", field1);
                  bad_offset(field1[2:0]);
               end
               default: begin
                  errors++;
                  $display("unknown command %c in the test data", cmd);
               end
            endcase
         end
         $fclose(fd);
      end

      repeat (20) @(negedge clk);
      if (rx_q.size() != 0) begin
         errors++;
         $display("%0d unexpected flits arrived on host_out", rx_q.size());
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: test/debug_testdata.txt
# R addr exp_sub exp_data | W addr data exp_sub (hex)
# U char (CPU write) | H char (host event) | X offset (unmapped UART offset)
R 0200 0 dead
R 0201 0 0002
R 0203 0 0000
W 0203 0003 e
R 0203 0 0003
W 0203 0001 e
R 0203 0 0001
W 0203 0002 e
R 0203 0 0002
W 0203 0000 e
R 0205 c 0000
W 0200 1234 f
U 41
U 5a
H 62
U 0d
H 7e
X 1
X 7
R 0200 0 dead

// File: sources.f
verilog/dii_pkg.sv
verilog/osd_reg_pkg.sv
verilog/dii_switch.sv
verilog/dii_pkt_decode.sv
verilog/scm_reg_execute.sv
verilog/dii_pkt_result.sv
verilog/osd_dem_uart.sv
verilog/debug_system.sv
test/debug_system_sva.sv
test/tb_debug_system.sv

// File: Makefile
TOP := tb_debug_system

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f sources.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
	cat sim.log
	! grep -q "Simulation failed" sim.log

clean:
	rm -rf obj_dir sim.log
